// File: mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;

    // fetch request, addr points at the first of two words
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data0;
        word_t data1;
        // low when word 1 falls outside the line or the fetch is uncached
        logic  data1_ok;
    } ibus_resp_t;

    // zero strobe means a load
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic       valid;
        logic       is_write;
        addr_t      addr;
        // beats minus one
        logic [1:0] len;
        strobe_t    strobe;
        word_t      data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

endpackage

`default_nettype wire

// File: cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // direct mapped, 8 lines of 4 words
    localparam int line_words  = 4;
    localparam int num_lines   = 8;
    localparam int offset_bits = 2;
    localparam int index_bits  = 3;
    localparam int tag_bits    = 25;

    typedef enum logic {
        ic_idle,
        ic_refill
    } icache_state_e;

    typedef enum logic [1:0] {
        dc_idle,
        dc_refill,
        dc_uncached_read,
        dc_write_through
    } dcache_state_e;

endpackage

`default_nettype wire

// File: addr_translate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_translate (
    input  mem_bus_pkg::ibus_req_t ireq_v,
    input  mem_bus_pkg::dbus_req_t dreq_v,
    output mem_bus_pkg::ibus_req_t ireq_p,
    output mem_bus_pkg::dbus_req_t dreq_p,
    output logic                   i_uncached,
    output logic                   d_uncached
);

    // kseg0 (100) and kseg1 (101) drop the segment bits, the rest is identity
    function automatic mem_bus_pkg::addr_t to_phys(input mem_bus_pkg::addr_t vaddr);
        if (vaddr[31:30] == 2'b10) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    always_comb begin
        ireq_p      = ireq_v;
        ireq_p.addr = to_phys(ireq_v.addr);
        dreq_p      = dreq_v;
        dreq_p.addr = to_phys(dreq_v.addr);
        // only kseg1 bypasses the caches
        i_uncached  = ireq_v.addr[31:29] == 3'b101;
        d_uncached  = dreq_v.addr[31:29] == 3'b101;
    end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mem_bus_pkg::ibus_req_t  ireq,
    input  logic                    uncached,
    input  mem_bus_pkg::cbus_resp_t cresp,
    output mem_bus_pkg::ibus_resp_t iresp,
    output mem_bus_pkg::cbus_req_t  creq
);

    cache_cfg_pkg::icache_state_e state;

    logic [cache_cfg_pkg::num_lines-1:0] valid_q;
    logic [cache_cfg_pkg::tag_bits-1:0]  tag_q [cache_cfg_pkg::num_lines];
    mem_bus_pkg::word_t data_q [cache_cfg_pkg::num_lines][cache_cfg_pkg::line_words];

    logic [cache_cfg_pkg::tag_bits-1:0]    tag;
    logic [cache_cfg_pkg::index_bits-1:0]  index;
    logic [cache_cfg_pkg::offset_bits-1:0] offset;
    logic [cache_cfg_pkg::offset_bits-1:0] next_offset;
    logic [cache_cfg_pkg::offset_bits-1:0] beat;
    mem_bus_pkg::addr_t                    line_addr;

    logic               hit;
    logic               lookup;
    logic               data_ok_q;
    logic               data1_ok_q;
    mem_bus_pkg::word_t data0_q;
    mem_bus_pkg::word_t data1_q;

    // bits [1:0] are the byte offset
    assign offset      = ireq.addr[2 +: cache_cfg_pkg::offset_bits];
    assign index       = ireq.addr[2 + cache_cfg_pkg::offset_bits +: cache_cfg_pkg::index_bits];
    assign tag         = ireq.addr[31 -: cache_cfg_pkg::tag_bits];
    assign next_offset = offset + 1'b1;
    assign line_addr   = {ireq.addr[31:2 + cache_cfg_pkg::offset_bits],
                          {(2 + cache_cfg_pkg::offset_bits){1'b0}}};

    assign hit    = !uncached && valid_q[index] && tag_q[index] == tag;
    // one response per request, skip the cycle data_ok is up
    assign lookup = state == cache_cfg_pkg::ic_idle && ireq.valid && !data_ok_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= cache_cfg_pkg::ic_idle;
            valid_q    <= '0;
            beat       <= '0;
            data_ok_q  <= 1'b0;
            data1_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state)
                cache_cfg_pkg::ic_idle: begin
                    if (lookup && hit) begin
                        data_ok_q  <= 1'b1;
                        data1_ok_q <= offset != '1;
                    end else if (lookup) begin
                        state <= cache_cfg_pkg::ic_refill;
                        beat  <= '0;
                        if (!uncached) begin
                            valid_q[index] <= 1'b0;
                        end
                    end
                end
                cache_cfg_pkg::ic_refill: begin
                    if (cresp.ready) begin
                        beat <= beat + 1'b1;
                        if (uncached) begin
                            data_ok_q  <= 1'b1;
                            data1_ok_q <= 1'b0;
                            state      <= cache_cfg_pkg::ic_idle;
                        end else if (cresp.last) begin
                            // hit is served on the next idle lookup
                            valid_q[index] <= 1'b1;
                            state          <= cache_cfg_pkg::ic_idle;
                        end
                    end
                end
                default: state <= cache_cfg_pkg::ic_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && hit) begin
            data0_q <= data_q[index][offset];
            data1_q <= data_q[index][next_offset];
        end
        if (lookup && !hit && !uncached) begin
            tag_q[index] <= tag;
        end
        if (state == cache_cfg_pkg::ic_refill && cresp.ready) begin
            if (uncached) begin
                data0_q <= cresp.data;
            end else begin
                data_q[index][beat] <= cresp.data;
            end
        end
    end

    assign iresp = '{data_ok: data_ok_q, data0: data0_q, data1: data1_q, data1_ok: data1_ok_q};

    always_comb begin
        creq       = '0;
        creq.valid = state == cache_cfg_pkg::ic_refill;
        creq.addr  = uncached ? ireq.addr : line_addr;
        creq.len   = uncached ? 2'd0 : 2'(cache_cfg_pkg::line_words - 1);
    end

endmodule

`default_nettype wire

// File: dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mem_bus_pkg::dbus_req_t  dreq,
    input  logic                    uncached,
    input  mem_bus_pkg::cbus_resp_t cresp,
    output mem_bus_pkg::dbus_resp_t dresp,
    output mem_bus_pkg::cbus_req_t  creq
);

    cache_cfg_pkg::dcache_state_e state;

    logic [cache_cfg_pkg::num_lines-1:0] valid_q;
    logic [cache_cfg_pkg::tag_bits-1:0]  tag_q [cache_cfg_pkg::num_lines];
    mem_bus_pkg::word_t data_q [cache_cfg_pkg::num_lines][cache_cfg_pkg::line_words];

    logic [cache_cfg_pkg::tag_bits-1:0]    tag;
    logic [cache_cfg_pkg::index_bits-1:0]  index;
    logic [cache_cfg_pkg::offset_bits-1:0] offset;
    logic [cache_cfg_pkg::offset_bits-1:0] beat;
    mem_bus_pkg::addr_t                    line_addr;

    logic               hit;
    logic               is_load;
    logic               lookup;
    logic               data_ok_q;
    mem_bus_pkg::word_t rdata_q;

    assign offset    = dreq.addr[2 +: cache_cfg_pkg::offset_bits];
    assign index     = dreq.addr[2 + cache_cfg_pkg::offset_bits +: cache_cfg_pkg::index_bits];
    assign tag       = dreq.addr[31 -: cache_cfg_pkg::tag_bits];
    assign line_addr = {dreq.addr[31:2 + cache_cfg_pkg::offset_bits],
                        {(2 + cache_cfg_pkg::offset_bits){1'b0}}};

    assign hit     = !uncached && valid_q[index] && tag_q[index] == tag;
    assign is_load = dreq.strobe == '0;
    assign lookup  = state == cache_cfg_pkg::dc_idle && dreq.valid && !data_ok_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= cache_cfg_pkg::dc_idle;
            valid_q   <= '0;
            beat      <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= 1'b0;
            case (state)
                cache_cfg_pkg::dc_idle: begin
                    if (lookup) begin
                        // stores always go to memory, hit or not
                        if (!is_load) begin
                            state <= cache_cfg_pkg::dc_write_through;
                        end else if (uncached) begin
                            state <= cache_cfg_pkg::dc_uncached_read;
                        end else if (hit) begin
                            data_ok_q <= 1'b1;
                        end else begin
                            state          <= cache_cfg_pkg::dc_refill;
                            beat           <= '0;
                            valid_q[index] <= 1'b0;
                        end
                    end
                end
                cache_cfg_pkg::dc_refill: begin
                    if (cresp.ready) begin
                        beat <= beat + 1'b1;
                        if (cresp.last) begin
                            valid_q[index] <= 1'b1;
                            state          <= cache_cfg_pkg::dc_idle;
                        end
                    end
                end
                cache_cfg_pkg::dc_uncached_read: begin
                    if (cresp.ready) begin
                        data_ok_q <= 1'b1;
                        state     <= cache_cfg_pkg::dc_idle;
                    end
                end
                default: begin
                    if (cresp.ready && cresp.last) begin
                        data_ok_q <= 1'b1;
                        state     <= cache_cfg_pkg::dc_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            cache_cfg_pkg::dc_idle: begin
                if (lookup && is_load && hit) begin
                    rdata_q <= data_q[index][offset];
                end
                if (lookup && is_load && !uncached && !hit) begin
                    tag_q[index] <= tag;
                end
            end
            cache_cfg_pkg::dc_refill: begin
                if (cresp.ready) begin
                    data_q[index][beat] <= cresp.data;
                end
            end
            cache_cfg_pkg::dc_uncached_read: begin
                if (cresp.ready) begin
                    rdata_q <= cresp.data;
                end
            end
            default: begin
                // store hit keeps the line in step with memory
                if (cresp.ready && cresp.last && hit) begin
                    for (int b = 0; b < 4; b++) begin
                        if (dreq.strobe[b]) begin
                            data_q[index][offset][8*b +: 8] <= dreq.data[8*b +: 8];
                        end
                    end
                end
            end
        endcase
    end

    assign dresp = '{data_ok: data_ok_q, data: rdata_q};

    always_comb begin
        creq          = '0;
        creq.valid    = state != cache_cfg_pkg::dc_idle;
        creq.is_write = state == cache_cfg_pkg::dc_write_through;
        creq.addr     = state == cache_cfg_pkg::dc_refill ? line_addr : dreq.addr;
        creq.len      = state == cache_cfg_pkg::dc_refill
                        ? 2'(cache_cfg_pkg::line_words - 1) : 2'd0;
        creq.strobe   = creq.is_write ? dreq.strobe : '0;
        creq.data     = dreq.data;
    end

endmodule

`default_nettype wire

// File: cbus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cbus_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  mem_bus_pkg::cbus_req_t  i_creq,
    input  mem_bus_pkg::cbus_req_t  d_creq,
    input  mem_bus_pkg::cbus_resp_t cresp,
    output mem_bus_pkg::cbus_resp_t i_cresp,
    output mem_bus_pkg::cbus_resp_t d_cresp,
    output mem_bus_pkg::cbus_req_t  creq
);

    logic busy;
    // 1 when the data cache holds the bus
    logic owner_d;
    logic grant_d;

    // data side wins when nothing is locked
    assign grant_d = busy ? owner_d : d_creq.valid;
    assign creq    = grant_d ? d_creq : i_creq;

    always_comb begin
        i_cresp = cresp;
        d_cresp = cresp;
        if (grant_d) begin
            i_cresp.ready = 1'b0;
            i_cresp.last  = 1'b0;
        end else begin
            d_cresp.ready = 1'b0;
            d_cresp.last  = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else if (creq.valid && cresp.ready && cresp.last) begin
            busy <= 1'b0;
        end else if (creq.valid && !busy) begin
            // lock until the last beat
            busy    <= 1'b1;
            owner_d <= grant_d;
        end
    end

endmodule

`default_nettype wire

// File: cache_manage.sv
`timescale 1ns/1ps
`default_nettype none

module cache_manage (
    input  logic                    clk,
    input  logic                    arst_n,

    input  mem_bus_pkg::ibus_req_t  ireq,
    output mem_bus_pkg::ibus_resp_t iresp,

    input  mem_bus_pkg::dbus_req_t  dreq,
    output mem_bus_pkg::dbus_resp_t dresp,

    output mem_bus_pkg::cbus_req_t  creq,
    input  mem_bus_pkg::cbus_resp_t cresp
);

    // physical requests
    mem_bus_pkg::ibus_req_t ireq_p;
    mem_bus_pkg::dbus_req_t dreq_p;
    logic                   i_uncached;
    logic                   d_uncached;

    // per cache memory bus
    mem_bus_pkg::cbus_req_t  i_creq;
    mem_bus_pkg::cbus_resp_t i_cresp;
    mem_bus_pkg::cbus_req_t  d_creq;
    mem_bus_pkg::cbus_resp_t d_cresp;

    addr_translate addr_translate (
        .ireq_v(ireq),
        .dreq_v(dreq),
        .ireq_p,
        .dreq_p,
        .i_uncached,
        .d_uncached
    );

    icache icache (
        .clk,
        .arst_n,
        .ireq(ireq_p),
        .uncached(i_uncached),
        .cresp(i_cresp),
        .iresp,
        .creq(i_creq)
    );

    dcache dcache (
        .clk,
        .arst_n,
        .dreq(dreq_p),
        .uncached(d_uncached),
        .cresp(d_cresp),
        .dresp,
        .creq(d_creq)
    );

    cbus_arbiter cbus_arbiter (
        .clk,
        .arst_n,
        .i_creq,
        .d_creq,
        .cresp,
        .i_cresp,
        .d_cresp,
        .creq
    );

endmodule

`default_nettype wire

// File: cache_manage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cache_manage_assertions (
    input logic                    clk,
    input logic                    arst_n,
    input mem_bus_pkg::cbus_req_t  creq,
    input mem_bus_pkg::cbus_resp_t cresp,
    input mem_bus_pkg::cbus_req_t  i_creq,
    input mem_bus_pkg::cbus_req_t  d_creq,
    input mem_bus_pkg::cbus_resp_t i_cresp,
    input mem_bus_pkg::cbus_resp_t d_cresp,
    input logic                    grant_d
);

    int   violations = 0;
    logic burst_open;

    // request out and its last beat not yet taken
    assign burst_open = creq.valid && !(cresp.ready && cresp.last);

    hold_request: assert property (
        @(posedge clk) disable iff (!arst_n) burst_open |=> creq.valid && $stable(creq.addr)
    ) else begin
        $error("memory request dropped or moved before its last beat");
        violations++;
    end

    reset_idle: assert property (@(posedge clk) !arst_n |=> !creq.valid) else begin
        $error("memory request valid while in reset");
        violations++;
    end

    // owner stays put for the whole burst
    owner_locked: assert property (
        @(posedge clk) disable iff (!arst_n) burst_open |=> $stable(grant_d)
    ) else begin
        $error("bus owner changed in the middle of a burst");
        violations++;
    end

    // a beat only reaches the cache whose pending request is on the bus
    data_owner_only: assert property (
        @(posedge clk) disable iff (!arst_n) d_cresp.ready |-> d_creq.valid && creq == d_creq
    ) else begin
        $error("data side got a beat for a request it does not hold on the bus");
        violations++;
    end

    fetch_owner_only: assert property (
        @(posedge clk) disable iff (!arst_n) i_cresp.ready |-> i_creq.valid && creq == i_creq
    ) else begin
        $error("fetch side got a beat for a request it does not hold on the bus");
        violations++;
    end

endmodule

bind cbus_arbiter cache_manage_assertions assertions (
    .clk,
    .arst_n,
    .creq,
    .cresp,
    .i_creq,
    .d_creq,
    .i_cresp,
    .d_cresp,
    .grant_d
);

`default_nettype wire

// File: tb_cache_manage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_manage;

    // op_fetch_first raises the load two cycles after the fetch
    typedef enum logic [1:0] {
        op_fetch,
        op_data,
        op_both,
        op_fetch_first
    } op_e;

    // vaddr2 is the load address of a combined fetch and load
    typedef struct packed {
        op_e                  port;
        mem_bus_pkg::addr_t   vaddr;
        mem_bus_pkg::addr_t   vaddr2;
        mem_bus_pkg::strobe_t strobe;
        mem_bus_pkg::word_t   data;
    } entry_t;

    logic clk = 1'b0;
    logic arst_n;

    mem_bus_pkg::ibus_req_t  ireq;
    mem_bus_pkg::ibus_resp_t iresp;
    mem_bus_pkg::dbus_req_t  dreq;
    mem_bus_pkg::dbus_resp_t dresp;
    mem_bus_pkg::cbus_req_t  creq;
    mem_bus_pkg::cbus_resp_t cresp;

    entry_t tests[$];
    string  names[$];

    mem_bus_pkg::word_t mem [1024];
    mem_bus_pkg::word_t ref_mem [1024];

    logic       mem_busy = 1'b0;
    logic       mem_write;
    logic [9:0] mem_word;
    logic [1:0] mem_len;
    logic [1:0] mem_beat;
    integer     seed = 46;
    int         cycles = 0;

    cache_manage dut (
        .clk,
        .arst_n,
        .ireq,
        .iresp,
        .dreq,
        .dresp,
        .creq,
        .cresp
    );

    always #4 clk = ~clk;

    // memory model, one idle cycle then a beat per cycle with random stalls
    always @(posedge clk) begin
        if (!arst_n) begin
            mem_busy = 1'b0;
        end else if (cresp.ready) begin
            if (mem_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (creq.strobe[b]) begin
                        mem[mem_word][8*b +: 8] = creq.data[8*b +: 8];
                    end
                end
            end
            if (cresp.last) begin
                mem_busy = 1'b0;
            end else begin
                mem_beat = mem_beat + 1'b1;
            end
        end else if (!mem_busy && creq.valid) begin
            mem_busy  = 1'b1;
            mem_write = creq.is_write;
            mem_word  = creq.addr[11:2];
            mem_len   = creq.len;
            mem_beat  = '0;
        end
        #1;
        cresp.ready = mem_busy && (($random(seed) & 3) != 0);
        cresp.last  = cresp.ready && mem_beat == mem_len;
        cresp.data  = mem[mem_word + {8'd0, mem_beat}];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > tests.size() * 40) begin
            $display("timeout, a request got no data_ok within %0d cycles", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // kseg0 and kseg1 drop the segment bits
    function automatic mem_bus_pkg::addr_t phys_addr(input mem_bus_pkg::addr_t va);
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    function automatic mem_bus_pkg::word_t merge_bytes(input mem_bus_pkg::word_t old_word,
                                                       input mem_bus_pkg::word_t new_word,
                                                       input mem_bus_pkg::strobe_t strobe);
        mem_bus_pkg::word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input string name, input mem_bus_pkg::word_t expected,
                               input mem_bus_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic add_entry(input string name, input op_e port, input mem_bus_pkg::addr_t vaddr,
                             input mem_bus_pkg::addr_t vaddr2, input mem_bus_pkg::strobe_t strobe,
                             input mem_bus_pkg::word_t data);
        entry_t e;
        e = '{port: port, vaddr: vaddr, vaddr2: vaddr2, strobe: strobe, data: data};
        tests.push_back(e);
        names.push_back(name);
    endtask

    task automatic apply_entry(input int n);
        entry_t             e;
        mem_bus_pkg::addr_t daddr;
        mem_bus_pkg::addr_t ipa;
        mem_bus_pkg::addr_t dpa;
        logic               i_wait;
        logic               d_wait;
        logic               line_end;
        int                 lag;
        e        = tests[n];
        daddr    = (e.port == op_both || e.port == op_fetch_first) ? e.vaddr2 : e.vaddr;
        ipa      = phys_addr(e.vaddr);
        dpa      = phys_addr(daddr);
        i_wait   = e.port != op_data;
        d_wait   = e.port != op_fetch;
        line_end = ipa[3:2] == 2'b11;
        lag      = e.port == op_fetch_first ? 2 : 0;
        ireq     = '{valid: i_wait, addr: e.vaddr};
        dreq     = '{valid: d_wait && lag == 0, addr: daddr, strobe: e.strobe, data: e.data};
        while (i_wait || d_wait) begin
            @(posedge clk);
            #1;
            // load arrives while the fetch refill holds the bus
            if (lag > 0) begin
                lag--;
                if (lag == 0) begin
                    dreq.valid = 1'b1;
                end
            end
            if (i_wait && iresp.data_ok) begin
                i_wait     = 1'b0;
                ireq.valid = 1'b0;
                check_value({names[n], ".data0"}, ref_mem[ipa[11:2]], iresp.data0);
                // word 1 only inside the line and only when cached
                check_value({names[n], ".data1_ok"},
                            {31'd0, !line_end && e.vaddr[31:29] != 3'b101},
                            {31'd0, iresp.data1_ok});
                if (iresp.data1_ok) begin
                    check_value({names[n], ".data1"}, ref_mem[ipa[11:2] + 10'd1], iresp.data1);
                end
            end
            if (d_wait && dresp.data_ok) begin
                d_wait     = 1'b0;
                dreq.valid = 1'b0;
                if (dreq.strobe == '0) begin
                    check_value({names[n], ".load"}, ref_mem[dpa[11:2]], dresp.data);
                end else begin
                    ref_mem[dpa[11:2]] = merge_bytes(ref_mem[dpa[11:2]], e.data, e.strobe);
                end
            end
        end
    endtask

    initial begin
        arst_n = 1'b0;
        ireq   = '0;
        dreq   = '0;
        cresp  = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i]     = (i * 4) ^ 32'hc3a5_96e1;
            ref_mem[i] = (i * 4) ^ 32'hc3a5_96e1;
        end
        add_entry("fetch_k0_miss", op_fetch, 32'h8000_0104, '0, '0, '0);
        add_entry("fetch_k0_hit", op_fetch, 32'h8000_0104, '0, '0, '0);
        add_entry("fetch_line_end", op_fetch, 32'h8000_010c, '0, '0, '0);
        add_entry("fetch_k1", op_fetch, 32'ha000_0208, '0, '0, '0);
        add_entry("load_k0_miss", op_data, 32'h8000_0300, '0, '0, '0);
        add_entry("load_k0_hit", op_data, 32'h8000_0300, '0, '0, '0);
        add_entry("store_hit_part", op_data, 32'h8000_0304, '0, 4'b0110, 32'h3c5a_e1f0);
        add_entry("load_after_store", op_data, 32'h8000_0304, '0, '0, '0);
        add_entry("load_k1_alias", op_data, 32'ha000_0304, '0, '0, '0);
        add_entry("store_miss", op_data, 32'h8000_0404, '0, 4'b1001, 32'h1234_5678);
        add_entry("load_useg_refill", op_data, 32'h0000_0404, '0, '0, '0);
        add_entry("both_miss", op_both, 32'h0000_0520, 32'h8000_0560, '0, '0);
        add_entry("both_uncached", op_both, 32'ha000_0630, 32'ha000_0634, '0, '0);
        add_entry("both_same_index", op_both, 32'h8000_0710, 32'h8000_0790, '0, '0);
        add_entry("fetch_then_load", op_fetch_first, 32'h8000_0840, 32'h8000_08c4, '0, '0);
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int n = 0; n < tests.size(); n++) begin
            @(posedge clk);
            #1;
            apply_entry(n);
        end
        repeat (2) @(posedge clk);
        if (dut.cbus_arbiter.assertions.violations != 0) begin
            $display("memory bus protocol broken %0d times",
                     dut.cbus_arbiter.assertions.violations);
            $display("RESULT: FAIL");
            $fatal(1, "bus assertions failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: cache_manage.f
mem_bus_pkg.sv
cache_cfg_pkg.sv
addr_translate.sv
icache.sv
dcache.sv
cbus_arbiter.sv
cache_manage.sv
cache_manage_assertions.sv
tb_cache_manage.sv

// File: Bender.yml
package:
  name: cache_manage

sources:
  - mem_bus_pkg.sv
  - cache_cfg_pkg.sv
  - addr_translate.sv
  - icache.sv
  - dcache.sv
  - cbus_arbiter.sv
  - cache_manage.sv
  - target: test
    files:
      - cache_manage_assertions.sv
      - tb_cache_manage.sv
